// File: axil_native_defines.svh
`ifndef AXIL_NATIVE_DEFINES_SVH
`define AXIL_NATIVE_DEFINES_SVH

// AXI4-Lite bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32
`define AXIL_STRB_W 4
`define AXI_RESP_W 2
`define AXI_ID_W 1

// Address bit that selects the register block when set
`define REGS_SEL_BIT 12

// SRAM holds 256 words, indexed by address bits 9 to 2
`define SRAM_DEPTH_LOG2 8

`define REGS_ID_VALUE 32'h1b0b0001 // Read at register offset 0

`endif

// File: axil_native_pkg.sv
`include "axil_native_defines.svh"

package axil_native_pkg;

   typedef logic [`AXIL_ADDR_W-1:0] addr_t;
   typedef logic [`AXIL_DATA_W-1:0] data_t;
   typedef logic [`AXIL_STRB_W-1:0] strb_t;
   typedef logic [`AXI_RESP_W-1:0] resp_t;

   // A read is a request whose strobes are all zero
   typedef struct packed {
      logic  valid;
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } native_req_t;

   typedef struct packed {
      logic  ready; // One-cycle pulse
      data_t rdata;
   } native_rsp_t;

   typedef enum logic [2:0] {
      BR_IDLE,
      BR_WRITE,
      BR_READ,
      BR_BRESP,
      BR_RRESP
   } bridge_state_t;

   // Replaces the bytes of old_word whose strobe is set
   function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                         input strb_t strb);
      data_t merged;
      merged = old_word;
      for (int i = 0; i < `AXIL_STRB_W; i++) begin
         if (strb[i]) merged[8*i +: 8] = new_word[8*i +: 8];
      end
      return merged;
   endfunction

endpackage

// File: axil2native.sv
`timescale 1ns/1ps
`include "axil_native_defines.svh"

module axil2native
   import axil_native_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 awvalid,
   output logic                 awready,
   input  addr_t                awaddr,
   input  logic                 wvalid,
   output logic                 wready,
   input  data_t                wdata,
   input  strb_t                wstrb,
   output logic                 bvalid,
   input  logic                 bready,
   output resp_t                bresp,
   output logic [`AXI_ID_W-1:0] bid,
   input  logic                 arvalid,
   output logic                 arready,
   input  addr_t                araddr,
   output logic                 rvalid,
   input  logic                 rready,
   output data_t                rdata,
   output resp_t                rresp,
   output logic [`AXI_ID_W-1:0] rid,
   output native_req_t          native_req,
   input  native_rsp_t          native_rsp
);

   bridge_state_t state;

   logic  start_write;
   logic  start_read;
   logic  req_valid;
   addr_t req_addr;
   data_t req_wdata;
   strb_t req_wstrb;

   assign start_write = awvalid & wvalid;
   assign start_read  = arvalid & ~start_write; // Writes win over reads

   // Address and data are taken together, only while idle
   assign awready = (state == BR_IDLE) & start_write;
   assign wready  = (state == BR_IDLE) & start_write;
   assign arready = (state == BR_IDLE) & start_read;

   assign bvalid = (state == BR_BRESP);
   assign rvalid = (state == BR_RRESP);

   // Every access completes with OKAY
   assign bresp = '0;
   assign rresp = '0;
   assign bid   = '0;
   assign rid   = '0;

   assign native_req = '{valid: req_valid, addr: req_addr, wdata: req_wdata, wstrb: req_wstrb};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= BR_IDLE;
         req_valid <= 1'b0;
      end else begin
         case (state)
            BR_IDLE: begin
               if (start_write) begin
                  state     <= BR_WRITE;
                  req_valid <= 1'b1;
               end else if (start_read) begin
                  state     <= BR_READ;
                  req_valid <= 1'b1;
               end
            end
            BR_WRITE: begin
               if (native_rsp.ready) begin
                  state     <= BR_BRESP;
                  req_valid <= 1'b0;
               end
            end
            BR_READ: begin
               if (native_rsp.ready) begin
                  state     <= BR_RRESP;
                  req_valid <= 1'b0;
               end
            end
            BR_BRESP: if (bready) state <= BR_IDLE;
            BR_RRESP: if (rready) state <= BR_IDLE;
            default:  state <= BR_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == BR_IDLE) begin
         if (start_write) begin
            req_addr  <= awaddr;
            req_wdata <= wdata;
            req_wstrb <= wstrb;
         end else if (start_read) begin
            req_addr  <= araddr;
            req_wstrb <= '0;
         end
      end
      // Read data is held until the master takes it
      if ((state == BR_READ) && native_rsp.ready) rdata <= native_rsp.rdata;
   end

endmodule

// File: native_decoder.sv
`timescale 1ns/1ps
`include "axil_native_defines.svh"

module native_decoder
   import axil_native_pkg::*;
(
   input  native_req_t bus_req,
   output native_req_t sram_req,
   output native_req_t regs_req,
   input  native_rsp_t sram_rsp,
   input  native_rsp_t regs_rsp,
   output native_rsp_t bus_rsp
);

   logic regs_sel;

   assign regs_sel = bus_req.addr[`REGS_SEL_BIT];

   // Payload reaches both targets, only the strobe is steered
   always_comb begin
      sram_req       = bus_req;
      regs_req       = bus_req;
      sram_req.valid = bus_req.valid & ~regs_sel;
      regs_req.valid = bus_req.valid & regs_sel;
   end

   // Every address lands in one of the two targets
   always_comb begin
      if (regs_sel) begin
         bus_rsp = regs_rsp;
      end else begin
         bus_rsp = sram_rsp;
      end
   end

endmodule

// File: native_sram.sv
`timescale 1ns/1ps
`include "axil_native_defines.svh"

module native_sram
   import axil_native_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  native_req_t req,
   output native_rsp_t rsp
);

   data_t mem [2**`SRAM_DEPTH_LOG2];

   logic [`SRAM_DEPTH_LOG2-1:0] idx;
   logic                        access;
   logic                        ready_q;
   data_t                       rdata_q;

   // Bits above the index and below the select bit alias
   assign idx    = req.addr[`SRAM_DEPTH_LOG2+1:2];
   assign access = req.valid & ~ready_q; // First cycle that valid is seen

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= access;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         if (|req.wstrb) mem[idx] <= merge_bytes(mem[idx], req.wdata, req.wstrb);
         rdata_q <= mem[idx];
      end
   end

   assign rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

// File: native_regs.sv
`timescale 1ns/1ps
`include "axil_native_defines.svh"

module native_regs
   import axil_native_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  native_req_t req,
   output native_rsp_t rsp
);

   localparam int NUM_SCRATCH = 7;

   data_t scratch [1:NUM_SCRATCH];

   logic [`REGS_SEL_BIT-3:0] offset;
   logic                     access;
   logic                     scratch_hit;
   logic                     ready_q;
   data_t                    rdata_q;
   data_t                    rd_word;

   assign offset      = req.addr[`REGS_SEL_BIT-1:2];
   assign access      = req.valid & ~ready_q;
   assign scratch_hit = (offset != 0) && (offset <= NUM_SCRATCH);

   // Offset 0 is the ID word, anything past the scratch words reads zero
   always_comb begin
      if (offset == 0) begin
         rd_word = `REGS_ID_VALUE;
      end else if (scratch_hit) begin
         rd_word = scratch[offset[2:0]];
      end else begin
         rd_word = '0;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ready_q <= 1'b0;
         for (int i = 1; i <= NUM_SCRATCH; i++) begin
            scratch[i] <= '0;
         end
      end else begin
         ready_q <= access;
         if (access && scratch_hit && (|req.wstrb)) begin
            scratch[offset[2:0]] <= merge_bytes(scratch[offset[2:0]], req.wdata, req.wstrb);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access) rdata_q <= rd_word; // Shown with the ready pulse
   end

   assign rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

// File: axil_native_top.sv
`timescale 1ns/1ps
`include "axil_native_defines.svh"

module axil_native_top
   import axil_native_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 awvalid,
   output logic                 awready,
   input  addr_t                awaddr,
   input  logic                 wvalid,
   output logic                 wready,
   input  data_t                wdata,
   input  strb_t                wstrb,
   output logic                 bvalid,
   input  logic                 bready,
   output resp_t                bresp,
   output logic [`AXI_ID_W-1:0] bid,
   input  logic                 arvalid,
   output logic                 arready,
   input  addr_t                araddr,
   output logic                 rvalid,
   input  logic                 rready,
   output data_t                rdata,
   output resp_t                rresp,
   output logic [`AXI_ID_W-1:0] rid
);

   native_req_t bus_req;
   native_req_t sram_req;
   native_req_t regs_req;
   native_rsp_t bus_rsp;
   native_rsp_t sram_rsp;
   native_rsp_t regs_rsp;

   axil2native bridge (
      .clk        (clk),
      .rst        (rst),
      .awvalid    (awvalid),
      .awready    (awready),
      .awaddr     (awaddr),
      .wvalid     (wvalid),
      .wready     (wready),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .bvalid     (bvalid),
      .bready     (bready),
      .bresp      (bresp),
      .bid        (bid),
      .arvalid    (arvalid),
      .arready    (arready),
      .araddr     (araddr),
      .rvalid     (rvalid),
      .rready     (rready),
      .rdata      (rdata),
      .rresp      (rresp),
      .rid        (rid),
      .native_req (bus_req),
      .native_rsp (bus_rsp)
   );

   native_decoder decoder (
      .bus_req  (bus_req),
      .sram_req (sram_req),
      .regs_req (regs_req),
      .sram_rsp (sram_rsp),
      .regs_rsp (regs_rsp),
      .bus_rsp  (bus_rsp)
   );

   native_sram sram (
      .clk (clk),
      .rst (rst),
      .req (sram_req),
      .rsp (sram_rsp)
   );

   native_regs regs (
      .clk (clk),
      .rst (rst),
      .req (regs_req),
      .rsp (regs_rsp)
   );

endmodule

// File: axil_native_properties.sv
`timescale 1ns/1ps

module axil_native_properties
   import axil_native_pkg::*;
(
   input logic        clk,
   input logic        rst,
   input logic        awready,
   input logic        wready,
   input logic        bvalid,
   input logic        bready,
   input resp_t       bresp,
   input logic        rvalid,
   input logic        rready,
   input data_t       rdata,
   input resp_t       rresp,
   input native_req_t bus_req,
   input native_rsp_t bus_rsp
);

   aw_with_w: assert property (@(posedge clk) disable iff (rst) awready |-> wready)
      else $error("awready without wready");

   b_held: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
      else $error("bvalid dropped before bready");

   r_held: assert property (@(posedge clk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(rdata))
      else $error("read response changed before rready");

   // The whole request, valid included, waits for the target
   req_held: assert property (@(posedge clk) disable iff (rst)
      bus_req.valid && !bus_rsp.ready |=> $stable(bus_req))
      else $error("native request changed before ready");

   req_drop: assert property (@(posedge clk) disable iff (rst)
      bus_req.valid && bus_rsp.ready |=> !bus_req.valid)
      else $error("native valid still high after ready");

   ready_pulse: assert property (@(posedge clk) disable iff (rst)
      bus_rsp.ready |=> !bus_rsp.ready)
      else $error("native ready high for two cycles");

   one_response: assert property (@(posedge clk) disable iff (rst) !(bvalid && rvalid))
      else $error("bvalid and rvalid high together");

   okay_resp: assert property (@(posedge clk) disable iff (rst) bresp == '0 && rresp == '0)
      else $error("response code other than OKAY");

endmodule

bind axil_native_top axil_native_properties props (
   .clk     (clk),
   .rst     (rst),
   .awready (awready),
   .wready  (wready),
   .bvalid  (bvalid),
   .bready  (bready),
   .bresp   (bresp),
   .rvalid  (rvalid),
   .rready  (rready),
   .rdata   (rdata),
   .rresp   (rresp),
   .bus_req (bus_req),
   .bus_rsp (bus_rsp)
);

// File: axil_native_tb.sv
`timescale 1ns/1ps
`include "axil_native_defines.svh"

module axil_native_tb
   import axil_native_pkg::*;
;

   localparam int     TIMEOUT   = 50;
   localparam int     LATENCY   = 3; // AXI acceptance edge to response valid
   localparam addr_t  REGS_BASE = addr_t'(1) << `REGS_SEL_BIT;

   typedef enum logic [1:0] {
      OP_WR,
      OP_RD,
      OP_WR_RD
   } op_t;

   typedef struct packed {
      op_t        op;
      addr_t      addr;
      data_t      data;
      logic       rnd_data;
      strb_t      strb;
      logic [3:0] stall;
      logic       rnd_stall;
   } stim_t;

   logic                 clk;
   logic                 rst;
   logic                 awvalid;
   logic                 awready;
   addr_t                awaddr;
   logic                 wvalid;
   logic                 wready;
   data_t                wdata;
   strb_t                wstrb;
   logic                 bvalid;
   logic                 bready;
   resp_t                bresp;
   logic [`AXI_ID_W-1:0] bid;
   logic                 arvalid;
   logic                 arready;
   addr_t                araddr;
   logic                 rvalid;
   logic                 rready;
   data_t                rdata;
   resp_t                rresp;
   logic [`AXI_ID_W-1:0] rid;

   stim_t stim_q[$];
   data_t sram_model [2**`SRAM_DEPTH_LOG2];
   data_t scratch_model [1:7];

   axil_native_top uut (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("FAILED at %0t: %s: got %h, expected %h", $time, what, actual, expected);
         $display("Simulation failed");
         $fatal(1, "Value mismatch");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timed out at %0t while waiting for %s", $time, what);
      $display("Simulation failed");
      $fatal(1, "Handshake timeout");
   endtask

   function automatic data_t apply_strobes(input data_t old_word, input data_t new_word,
                                           input strb_t strb);
      data_t mask;
      mask = '0;
      for (int b = 0; b < `AXIL_STRB_W; b++) begin
         if (strb[b]) mask[8*b +: 8] = 8'hff;
      end
      return (old_word & ~mask) | (new_word & mask);
   endfunction

   // The SRAM shadow aliases every 1 KiB below the register block
   task automatic model_write(input addr_t addr, input data_t data, input strb_t strb);
      int off;
      off = int'(addr[`REGS_SEL_BIT-1:2]);
      if (!addr[`REGS_SEL_BIT]) begin
         sram_model[addr[9:2]] = apply_strobes(sram_model[addr[9:2]], data, strb);
      end else if (off >= 1 && off <= 7) begin
         scratch_model[off] = apply_strobes(scratch_model[off], data, strb);
      end
   endtask

   function automatic data_t expected_read(input addr_t addr);
      int off;
      off = int'(addr[`REGS_SEL_BIT-1:2]);
      if (!addr[`REGS_SEL_BIT]) return sram_model[addr[9:2]];
      if (off == 0) return `REGS_ID_VALUE;
      if (off <= 7) return scratch_model[off];
      return '0;
   endfunction

   // Holds back the response and probes that nothing new is accepted meanwhile
   task automatic stall_response(input int cycles, input logic is_read, input logic keep_ar);
      data_t held;
      held = rdata;
      if (cycles > 0) begin
         wstrb   = '0;
         awvalid = 1'b1;
         wvalid  = 1'b1;
         arvalid = 1'b1;
      end
      for (int i = 0; i < cycles; i++) begin
         #1;
         check_value(32'({awready, wready, arready}), 32'd0, "handshake during stall");
         @(negedge clk);
         check_value(32'({bvalid, rvalid}), 32'({~is_read, is_read}), "response valid dropped");
         if (is_read) check_value(rdata, held, "rdata changed during stall");
      end
      awvalid = 1'b0;
      wvalid  = 1'b0;
      arvalid = keep_ar;
   endtask

   // Both master tasks start and end right at a falling edge
   task automatic axil_write(input addr_t addr, input data_t data, input strb_t strb,
                             input int stall, input logic keep_ar, output int latency);
      int n;
      awaddr  = addr;
      wdata   = data;
      wstrb   = strb;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      n = 0;
      #1;
      while (!(awready && wready)) begin
         n++;
         if (n > TIMEOUT) report_timeout("awready and wready");
         @(negedge clk);
         #1;
      end
      check_value(32'(arready), 32'd0, "arready while a write is accepted");
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      latency = 1;
      while (!bvalid) begin
         if (latency > TIMEOUT) report_timeout("bvalid");
         @(negedge clk);
         latency++;
      end
      check_value(32'({bresp, bid}), 32'd0, "write response code and ID");
      stall_response(stall, 1'b0, keep_ar);
      bready = 1'b1;
      #1;
      check_value(32'(arready), 32'd0, "arready in the write response cycle");
      @(negedge clk);
      bready = 1'b0;
      check_value(32'(bvalid), 32'd0, "bvalid after its handshake");
   endtask

   task automatic axil_read(input addr_t addr, input int stall, output data_t data,
                            output int latency);
      int n;
      araddr  = addr;
      arvalid = 1'b1;
      n = 0;
      #1;
      while (!arready) begin
         n++;
         if (n > TIMEOUT) report_timeout("arready");
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      arvalid = 1'b0;
      latency = 1;
      while (!rvalid) begin
         if (latency > TIMEOUT) report_timeout("rvalid");
         @(negedge clk);
         latency++;
      end
      check_value(32'({rresp, rid}), 32'd0, "read response code and ID");
      data = rdata;
      stall_response(stall, 1'b1, 1'b0);
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
      check_value(32'(rvalid), 32'd0, "rvalid after its handshake");
   endtask

   task automatic add_entry(input op_t op, input addr_t addr, input data_t data,
                            input logic rnd_data, input strb_t strb, input logic [3:0] stall,
                            input logic rnd_stall);
      stim_q.push_back('{op, addr, data, rnd_data, strb, stall, rnd_stall});
   endtask

   task automatic build_table();
      for (int i = 1; i <= 7; i++) begin
         add_entry(OP_RD, REGS_BASE + addr_t'(4*i), '0, 1'b0, '0, 4'd0, 1'b0);
      end
      add_entry(OP_RD, 32'h0000_1000, '0, 1'b0, '0, 4'd0, 1'b0);
      add_entry(OP_WR, 32'h0000_1000, 32'hffff_ffff, 1'b0, 4'hf, 4'd0, 1'b0);
      add_entry(OP_RD, 32'h0000_1000, '0, 1'b0, '0, 4'd0, 1'b0);
      add_entry(OP_WR, 32'h0000_0000, '0, 1'b1, 4'hf, 4'd0, 1'b0);
      add_entry(OP_WR, 32'h0000_0004, 32'h1122_3344, 1'b0, 4'hf, 4'd0, 1'b0);
      add_entry(OP_WR, 32'h0000_03fc, '0, 1'b1, 4'hf, 4'd0, 1'b0);
      add_entry(OP_WR, 32'h0000_0808, '0, 1'b1, 4'hf, 4'd0, 1'b0);
      add_entry(OP_WR, 32'h0000_0000, 32'haabb_ccdd, 1'b0, 4'b0001, 4'd0, 1'b0);
      add_entry(OP_WR, 32'h0000_0004, 32'h5566_7788, 1'b0, 4'b0110, 4'd0, 1'b0);
      add_entry(OP_WR, 32'h0000_03fc, 32'h9999_9999, 1'b0, 4'b1100, 4'd0, 1'b0);
      add_entry(OP_RD, 32'h0000_0000, '0, 1'b0, '0, 4'd0, 1'b0);
      add_entry(OP_RD, 32'h0000_0004, '0, 1'b0, '0, 4'd0, 1'b0);
      add_entry(OP_RD, 32'h0000_03fc, '0, 1'b0, '0, 4'd0, 1'b0);
      add_entry(OP_RD, 32'h0000_0008, '0, 1'b0, '0, 4'd0, 1'b0);
      add_entry(OP_RD, 32'h0000_0404, '0, 1'b0, '0, 4'd0, 1'b0);
      add_entry(OP_RD, 32'h0000_0c00, '0, 1'b0, '0, 4'd0, 1'b0);
      add_entry(OP_WR, 32'h0000_1004, 32'h1234_5678, 1'b0, 4'hf, 4'd0, 1'b0);
      add_entry(OP_WR, 32'h0000_1004, 32'hffff_ffff, 1'b0, 4'b0010, 4'd0, 1'b0);
      add_entry(OP_RD, 32'h0000_1004, '0, 1'b0, '0, 4'd0, 1'b0);
      add_entry(OP_WR, 32'h0000_1018, '0, 1'b1, 4'b0011, 4'd0, 1'b0);
      add_entry(OP_WR, 32'h0000_101c, '0, 1'b1, 4'b1001, 4'd0, 1'b0);
      add_entry(OP_RD, 32'h0000_1018, '0, 1'b0, '0, 4'd0, 1'b0);
      add_entry(OP_RD, 32'h0000_101c, '0, 1'b0, '0, 4'd0, 1'b0);
      add_entry(OP_WR, 32'h0000_1020, 32'hdead_beef, 1'b0, 4'hf, 4'd0, 1'b0);
      add_entry(OP_RD, 32'h0000_1020, '0, 1'b0, '0, 4'd0, 1'b0);
      add_entry(OP_WR, 32'h0000_1ffc, '0, 1'b1, 4'hf, 4'd0, 1'b0);
      add_entry(OP_RD, 32'h0000_1ffc, '0, 1'b0, '0, 4'd0, 1'b0);
      add_entry(OP_WR, 32'h0000_0010, '0, 1'b1, 4'hf, 4'd0, 1'b1);
      add_entry(OP_RD, 32'h0000_0010, '0, 1'b0, '0, 4'd0, 1'b1);
      add_entry(OP_WR, 32'h0000_1008, '0, 1'b1, 4'b0101, 4'd0, 1'b1);
      add_entry(OP_RD, 32'h0000_1008, '0, 1'b0, '0, 4'd0, 1'b1);
      add_entry(OP_RD, 32'h0000_1000, '0, 1'b0, '0, 4'd5, 1'b0);
      add_entry(OP_WR_RD, 32'h0000_0020, '0, 1'b1, 4'hf, 4'd0, 1'b0);
      add_entry(OP_WR_RD, 32'h0000_100c, 32'hcafe_0000, 1'b0, 4'b1100, 4'd2, 1'b0);
   endtask

   initial begin
      stim_t e;
      data_t wdata_v;
      data_t got;
      int    stall_v;
      int    lat;
      void'($urandom(32'hfaaaf2b1));
      rst     = 1'b1;
      awvalid = 1'b0;
      awaddr  = '0;
      wvalid  = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      bready  = 1'b0;
      arvalid = 1'b0;
      araddr  = '0;
      rready  = 1'b0;
      for (int i = 1; i <= 7; i++) scratch_model[i] = '0;
      build_table();
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      check_value(32'({bvalid, rvalid, awready, arready}), 32'd0, "outputs after reset");
      foreach (stim_q[i]) begin
         e       = stim_q[i];
         wdata_v = e.rnd_data ? $urandom : e.data;
         stall_v = e.rnd_stall ? int'($urandom_range(8, 1)) : int'(e.stall);
         if (e.op != OP_RD) begin
            araddr  = e.addr;
            arvalid = (e.op == OP_WR_RD); // Read raised together with the write
            axil_write(e.addr, wdata_v, e.strb, stall_v, e.op == OP_WR_RD, lat);
            check_value(32'(lat), 32'(LATENCY), $sformatf("write latency at %h", e.addr));
            model_write(e.addr, wdata_v, e.strb);
         end
         if (e.op != OP_WR) begin
            axil_read(e.addr, stall_v, got, lat);
            check_value(32'(lat), 32'(LATENCY), $sformatf("read latency at %h", e.addr));
            check_value(got, expected_read(e.addr), $sformatf("read data at %h", e.addr));
         end
      end
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// File: compile.f
+incdir+.
axil_native_pkg.sv
axil2native.sv
native_decoder.sv
native_sram.sv
native_regs.sv
axil_native_top.sv
axil_native_properties.sv
axil_native_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
EXE=axil_native_sim

verilator --binary --timing --assert -Wno-fatal \
   -f compile.f --top-module axil_native_tb -o "$EXE"
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/"$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation run ended with status $status"
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi
